//--- all.f
rd_pkg.sv
rdata_en_align.sv
read_fifo.sv
rdata_mapper.sv
oct_ctrl.sv
read_datapath.sv
read_datapath_assert.sv
tb_read_datapath.sv

//--- oct_ctrl.sv
/*
 * On-die termination override for reads
 * Keeps OCT off over a window derived from the memory read latency
 */
module oct_ctrl #(
	parameter int MEM_T_RL = 6
)
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic rdata_en_full_i,
	output logic force_oct_off_o
);

	// Window start and end in AFI cycles after the full read enable
	localparam int OCT_ON_DELAY  = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Bit j of the history is the enable sampled j+1 edges ago
	logic [OCT_OFF_DELAY-1:0] en_hist;
	logic [OCT_OFF_DELAY:0]   en_shift;

	// Bit 0 is the enable that is being sampled at this edge
	assign en_shift = {en_hist, rdata_en_full_i};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist         <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			en_hist         <= en_shift[OCT_OFF_DELAY-1:0];
			// Any enable inside the window keeps termination under normal control
			force_oct_off_o <= ~(|en_shift[OCT_OFF_DELAY:OCT_ON_DELAY]);
		end
	end

endmodule

//--- rd_pkg.sv
/*
 * Shared widths and derived constants of the full-rate read datapath
 * Packed structs for one group's DDIO word and the stage-1 control pair
 */
package rd_pkg;

	// ********************
	// Interface widths
	// ********************

	// Number of DQ pins on the memory side
	parameter int MEM_DQ_WIDTH = 16;
	// Number of read DQS groups
	parameter int NUM_DQS_GROUPS = 2;
	// DQ pins that belong to one DQS group
	parameter int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / NUM_DQS_GROUPS;
	// Full rate with DDR capture gives two time slots per AFI cycle
	parameter int AFI_DATA_WIDTH = 2 * MEM_DQ_WIDTH;
	// Data of one group in one AFI cycle
	parameter int GROUP_DATA_WIDTH = 2 * DQ_GROUP_WIDTH;
	// Width of the sequencer latency setting
	parameter int LAT_CNT_WIDTH = 5;

	// One group's DDIO output, slot1 is the later beat and sits on top
	typedef struct packed {
		logic [DQ_GROUP_WIDTH-1:0] slot1;
		logic [DQ_GROUP_WIDTH-1:0] slot0;
	} ddio_group_t;

	// Stage 1 output, the FIFO pop strobe and the data valid qualifier
	typedef struct packed {
		logic read_enable;
		logic read_valid;
	} rd_ctrl_t;

endpackage

//--- rdata_en_align.sv
/*
 * Read request alignment, stage 1 of the read datapath
 * Optional extra request delay, latency shift register and tap select
 */
module rdata_en_align
	import rd_pkg::*;
#(
	parameter int EXTRA_VFIFO_SHIFT = 0,
	parameter int MAX_READ_LATENCY = 16
)
(
	input  logic                     pll_afi_clk,
	input  logic                     reset_n_afi_clk,
	input  logic                     rdata_en_i,
	input  logic [LAT_CNT_WIDTH-1:0] latency_i,
	output rd_ctrl_t                 ctrl_o
);

	localparam int TAP_W = $clog2(MAX_READ_LATENCY);
	localparam logic [LAT_CNT_WIDTH-1:0] MAX_LAT = LAT_CNT_WIDTH'(MAX_READ_LATENCY);

	// Request after the optional extra delay
	logic rdata_en_int;

	// ********************
	// Extra request delay
	// ********************
	if (EXTRA_VFIFO_SHIFT >= 1)
	begin : g_extra_shift
		logic [EXTRA_VFIFO_SHIFT-1:0] extra_q;
		logic [EXTRA_VFIFO_SHIFT:0]   extra_next;

		// New request enters at bit 0, the oldest one leaves at the top
		assign extra_next = {extra_q, rdata_en_i};

		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
				extra_q <= '0;
			else
				extra_q <= extra_next[EXTRA_VFIFO_SHIFT-1:0];
		end

		assign rdata_en_int = extra_q[EXTRA_VFIFO_SHIFT-1];
	end
	else
	begin : g_no_shift
		assign rdata_en_int = rdata_en_i;
	end

	// ********************
	// Latency shifter
	// ********************
	// Bit j holds the request that entered j+1 edges ago, so several reads
	// can be in flight at the same time
	logic [MAX_READ_LATENCY-1:0] lat_q;
	logic [MAX_READ_LATENCY:0]   lat_next;
	logic [TAP_W-1:0]            tap_idx;
	logic                        tap;

	assign lat_next = {lat_q, rdata_en_int};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			lat_q <= '0;
		else
			lat_q <= lat_next[MAX_READ_LATENCY-1:0];
	end

	// Latency L selects bit L-1, a setting outside 1..MAX gives no read
	assign tap_idx = TAP_W'(latency_i - 1'b1);

	always_comb
	begin
		tap = 1'b0;
		if ((latency_i != '0) && (latency_i <= MAX_LAT))
			tap = lat_q[tap_idx];
	end

	// At full rate the pop strobe and the valid come from the same tap
	assign ctrl_o.read_enable = tap;
	assign ctrl_o.read_valid  = tap;

endmodule

//--- rdata_mapper.sv
/*
 * Output register and reordering for stage 3 of the read datapath
 * AFI read data is slot-major and the sequencer copy is group-major
 */
module rdata_mapper
	import rd_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  logic                      valid_i,
	input  ddio_group_t               group_data_i [NUM_DQS_GROUPS],
	output logic [AFI_DATA_WIDTH-1:0] afi_rdata_o,
	output logic                      afi_rdata_valid_o,
	output logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_o
);

	ddio_group_t data_q [NUM_DQS_GROUPS];

	// Read valid lags the stage-1 tap by one edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= 1'b0;
		else
			afi_rdata_valid_o <= valid_i;
	end

	// Group words move through the same register stage as the valid
	always_ff @(posedge pll_afi_clk)
	begin
		data_q <= group_data_i;
	end

	// ********************
	// Data reordering
	// ********************
	// AFI order is slot1 of every group above slot0 of every group,
	// the sequencer copy keeps both slots of a group next to each other
	always_comb
	begin
		for (int g = 0; g < NUM_DQS_GROUPS; g++)
		begin
			afi_rdata_o[(NUM_DQS_GROUPS + g) * DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] = data_q[g].slot1;
			afi_rdata_o[g * DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] = data_q[g].slot0;
			phy_mux_read_fifo_q_o[g * GROUP_DATA_WIDTH +: GROUP_DATA_WIDTH] = data_q[g];
		end
	end

endmodule

//--- read_datapath.sv
/*
 * Top level of the full-rate read datapath on the AFI clock
 * Request alignment, per-group read FIFOs, output mapping and OCT window
 */
module read_datapath
	import rd_pkg::*;
#(
	parameter int EXTRA_VFIFO_SHIFT = 1,
	parameter int MAX_READ_LATENCY = 16,
	parameter int FIFO_DEPTH = 8,
	parameter int FIFO_ADDR_WIDTH = 3,
	parameter int MEM_T_RL = 6
)
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  logic                      afi_rdata_en_i,
	input  logic                      afi_rdata_en_full_i,
	input  logic [LAT_CNT_WIDTH-1:0]  seq_read_latency_counter_i,
	input  logic [NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i,
	input  logic                      ddio_wr_en_i,
	input  logic [AFI_DATA_WIDTH-1:0] ddio_phy_dq_i,
	output logic [AFI_DATA_WIDTH-1:0] afi_rdata_o,
	output logic                      afi_rdata_valid_o,
	output logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_o,
	output logic                      force_oct_off_o
);

	rd_ctrl_t                  rd_ctrl;
	logic [NUM_DQS_GROUPS-1:0] fifo_clear_q;
	ddio_group_t               fifo_rd_data [NUM_DQS_GROUPS];

	// Stage 1 turns the request into a pop strobe and a valid
	rdata_en_align #(
		.EXTRA_VFIFO_SHIFT (EXTRA_VFIFO_SHIFT),
		.MAX_READ_LATENCY  (MAX_READ_LATENCY)
	) u_en_align (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_i      (afi_rdata_en_i),
		.latency_i       (seq_read_latency_counter_i),
		.ctrl_o          (rd_ctrl)
	);

	// Sequencer clear is registered once before it reaches the pointers
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			fifo_clear_q <= '0;
		else
			fifo_clear_q <= seq_read_fifo_reset_i;
	end

	// ********************
	// Per-group FIFOs
	// ********************
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : g_group
		ddio_group_t wr_word;

		// Input bus is group-major with slot1 above slot0 inside a group
		assign wr_word = ddio_group_t'(ddio_phy_dq_i[g * GROUP_DATA_WIDTH +: GROUP_DATA_WIDTH]);

		read_fifo #(
			.FIFO_DEPTH      (FIFO_DEPTH),
			.FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
		) u_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.clear_i         (fifo_clear_q[g]),
			.wr_en_i         (ddio_wr_en_i),
			.wr_data_i       (wr_word),
			.rd_en_i         (rd_ctrl.read_enable),
			.rd_data_o       (fifo_rd_data[g])
		);
	end

	// Stage 3 registers the words and orders them for AFI and the sequencer
	rdata_mapper u_mapper (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.valid_i               (rd_ctrl.read_valid),
		.group_data_i          (fifo_rd_data),
		.afi_rdata_o           (afi_rdata_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o)
	);

	oct_ctrl #(
		.MEM_T_RL (MEM_T_RL)
	) u_oct (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o (force_oct_off_o)
	);

endmodule

//--- read_datapath_assert.sv
/*
 * Concurrent checks bound into the read datapath top level
 * Valid during reset, start of the OCT window, FIFO clear against pop
 */
module read_datapath_assert
	import rd_pkg::*;
(
	input logic                      pll_afi_clk,
	input logic                      reset_n_afi_clk,
	input logic                      rdata_valid_i,
	input logic                      rdata_en_full_i,
	input logic                      force_oct_off_i,
	input logic [NUM_DQS_GROUPS-1:0] fifo_clear_i,
	input rd_ctrl_t                  ctrl_i
);

	// One edge inside reset is enough to pull the registered valid low
	a_valid_low_in_reset : assert property (
		@(posedge pll_afi_clk) !reset_n_afi_clk |=> !rdata_valid_i
	) else $error("Read valid is high while reset is held");

	// A full enable sampled now shows up in the registered OCT output two edges on
	a_oct_window_start : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		rdata_en_full_i |-> ##2 !force_oct_off_i
	) else $error("OCT override still high one cycle after a full read enable");

	// The pointer clear and a pop in the same cycle would lose the read word
	a_no_clear_on_pop : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(|fifo_clear_i) |-> !ctrl_i.read_enable
	) else $error("Read FIFO clear coincides with a FIFO pop");

endmodule

//--- read_datapath_testdata.txt
// Columns: flags, latency, write word (group-major), expected afi_rdata_o (slot-major)
// Flags: bit0 last word of a burst, bit1 clear the FIFOs first, bit2 write only
0 3 11223344 11332244
0 3 a5a55a5a a55aa55a
0 3 0f1e2d3c 0f2d1e3c
1 3 80706050 80607050
1 7 deadbeef debeadef
0 c 01020304 01030204
0 c fedcba98 febadc98
1 c 13579bdf 139b57df
4 5 cafef00d 00000000
5 5 0badc0de 00000000
2 5 55aa33cc 5533aacc
0 5 76543210 76325410
1 5 c3d2e1f0 c3e1d2f0

//--- read_fifo.sv
/*
 * Read data FIFO of one DQS group, stage 2 of the read datapath
 * Flop memory with wrapping write and read pointers and a pointer clear
 */
module read_fifo
	import rd_pkg::*;
#(
	parameter int FIFO_DEPTH = 8,
	parameter int FIFO_ADDR_WIDTH = 3
)
(
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,
	input  logic        clear_i,
	input  logic        wr_en_i,
	input  ddio_group_t wr_data_i,
	input  logic        rd_en_i,
	output ddio_group_t rd_data_o
);

	localparam logic [FIFO_ADDR_WIDTH-1:0] LAST_ADDR = FIFO_ADDR_WIDTH'(FIFO_DEPTH - 1);

	ddio_group_t mem [FIFO_DEPTH];

	logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
	logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;

	// Pointer increment that also wraps for a depth that is not a power of two
	function automatic logic [FIFO_ADDR_WIDTH-1:0] next_ptr(input logic [FIFO_ADDR_WIDTH-1:0] ptr);
		if (ptr == LAST_ADDR)
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	// ********************
	// Write side
	// ********************
	// A write while full simply overwrites the oldest word
	always_ff @(posedge pll_afi_clk)
	begin
		if (wr_en_i && !clear_i)
			mem[wr_ptr] <= wr_data_i;
	end

	// ********************
	// Pointers
	// ********************
	// The sequencer clear zeroes both pointers in the same cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (clear_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en_i)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en_i)
				rd_ptr <= next_ptr(rd_ptr);
		end
	end

	// The word at the read pointer is shown ahead of the pop
	assign rd_data_o = mem[rd_ptr];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the read datapath testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_read_datapath
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module "$TOP" -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- tb_read_datapath.sv
/*
 * Testbench of the full-rate read datapath
 * File-driven write and read bursts, FIFO clear and OCT enable patterns
 * Reference model for read valid, read data order and the OCT window
 */
module tb_read_datapath
	import rd_pkg::*;
();

	// ********************
	// Test constants
	// ********************
	localparam int EXTRA_SHIFT = 1;
	localparam int MAX_LAT     = 16;
	localparam int T_RL        = 6;
	localparam int OCT_ON      = (T_RL > 4) ? ((T_RL - 4) / 2) : 0;
	localparam int OCT_OFF     = (T_RL + 6) / 2;
	// Enables sampled OCT_ON to OCT_OFF edges back keep termination under normal control
	localparam logic [31:0] OCT_WINDOW = ((32'h1 << (OCT_OFF + 1)) - 32'h1)
		& ~((32'h1 << OCT_ON) - 32'h1);
	localparam int NUM_REC     = 13;
	localparam int NUM_COL     = 4;
	localparam int IDX_W       = $clog2(NUM_REC * NUM_COL);
	localparam int CYCLE_LIMIT = NUM_REC * (MAX_LAT + 8);
	localparam logic [31:0] FLAG_LAST   = 32'h1;
	localparam logic [31:0] FLAG_CLEAR  = 32'h2;
	localparam logic [31:0] FLAG_WRONLY = 32'h4;

	logic                      pll_afi_clk;
	logic                      reset_n_afi_clk;
	logic                      afi_rdata_en_i;
	logic                      afi_rdata_en_full_i;
	logic [LAT_CNT_WIDTH-1:0]  seq_read_latency_counter_i;
	logic [NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i;
	logic                      ddio_wr_en_i;
	logic [AFI_DATA_WIDTH-1:0] ddio_phy_dq_i;
	logic [AFI_DATA_WIDTH-1:0] afi_rdata_o;
	logic                      afi_rdata_valid_o;
	logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_o;
	logic                      force_oct_off_o;

	// Four columns of the data file for every record
	logic [31:0] tdata [NUM_REC * NUM_COL];
	// Expected words in request order with one entry per outstanding read
	logic [31:0] exp_afi_q [$];
	logic [31:0] exp_phy_q [$];

	int          cyc = 0;
	int          oct_cycles = 0;
	logic [31:0] req_hist = '0;
	logic [31:0] full_hist = '0;

	read_datapath #(
		.EXTRA_VFIFO_SHIFT (EXTRA_SHIFT),
		.MAX_READ_LATENCY  (MAX_LAT),
		.FIFO_DEPTH        (8),
		.FIFO_ADDR_WIDTH   (3),
		.MEM_T_RL          (T_RL)
	) dut0 (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
		.ddio_wr_en_i               (ddio_wr_en_i),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.afi_rdata_o                (afi_rdata_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	bind read_datapath read_datapath_assert u_assert (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_valid_i   (afi_rdata_valid_o),
		.rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_i (force_oct_off_o),
		.fifo_clear_i    (fifo_clear_q),
		.ctrl_i          (rd_ctrl)
	);

	always #10 pll_afi_clk = ~pll_afi_clk;

	// ********************
	// Helpers
	// ********************
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] rec_field(input int r, input int c);
		return tdata[IDX_W'(r * NUM_COL + c)];
	endfunction

	// The clear is registered in the DUT, so give it two idle edges to land
	task automatic clear_fifos();
		@(posedge pll_afi_clk);
		seq_read_fifo_reset_i <= '1;
		@(posedge pll_afi_clk);
		seq_read_fifo_reset_i <= '0;
		repeat (2) @(posedge pll_afi_clk);
	endtask

	task automatic write_burst(input int first, input int last);
		for (int r = first; r <= last; r++)
		begin
			@(posedge pll_afi_clk);
			ddio_wr_en_i  <= 1'b1;
			ddio_phy_dq_i <= AFI_DATA_WIDTH'(rec_field(r, 2));
		end
		@(posedge pll_afi_clk);
		ddio_wr_en_i <= 1'b0;
	endtask

	// Back-to-back requests that each carry a full-rate OCT enable
	task automatic read_burst(input int first, input int last);
		int gap;
		gap = int'($urandom % 4);
		repeat (gap) @(posedge pll_afi_clk);
		for (int r = first; r <= last; r++)
		begin
			@(posedge pll_afi_clk);
			afi_rdata_en_i      <= 1'b1;
			afi_rdata_en_full_i <= 1'b1;
			exp_afi_q.push_back(rec_field(r, 3));
			// The sequencer copy is group-major just like the DDIO input
			exp_phy_q.push_back(rec_field(r, 2));
		end
		@(posedge pll_afi_clk);
		afi_rdata_en_i      <= 1'b0;
		afi_rdata_en_full_i <= 1'b0;
	endtask

	// Waits for every outstanding word, then lets the OCT window close
	task automatic wait_drain();
		while (exp_afi_q.size() != 0)
			@(posedge pll_afi_clk);
		repeat (8) @(posedge pll_afi_clk);
	endtask

	task automatic pulse_full_enable(input int len);
		for (int i = 0; i < len; i++)
		begin
			@(posedge pll_afi_clk);
			afi_rdata_en_full_i <= 1'b1;
		end
		@(posedge pll_afi_clk);
		afi_rdata_en_full_i <= 1'b0;
		repeat (OCT_OFF + 2) @(posedge pll_afi_clk);
	endtask

	// ********************
	// Reference model and monitor
	// ********************
	// Outputs are compared at the falling edge, half a cycle after they change
	always @(negedge pll_afi_clk)
	begin
		logic [31:0] lat_shift;
		logic        exp_oct;
		cyc = cyc + 1;
		if (cyc > CYCLE_LIMIT)
			abort_run($sformatf("Timeout, the run went past %0d cycles", CYCLE_LIMIT));
		if (reset_n_afi_clk)
		begin
			// Valid follows the request sampled E plus L edges earlier
			lat_shift = req_hist >> (EXTRA_SHIFT + int'(seq_read_latency_counter_i));
			check_value("afi_rdata_valid_o", 32'(afi_rdata_valid_o), 32'(lat_shift[0]));
			if (afi_rdata_valid_o)
			begin
				if (exp_afi_q.size() == 0)
					abort_run("Read valid seen with no read outstanding");
				check_value("afi_rdata_o", 32'(afi_rdata_o), exp_afi_q.pop_front());
				check_value("phy_mux_read_fifo_q_o", 32'(phy_mux_read_fifo_q_o),
					exp_phy_q.pop_front());
			end
			// OCT override comes out of reset low for one cycle
			exp_oct = (oct_cycles != 0) && ((full_hist & OCT_WINDOW) == '0);
			check_value("force_oct_off_o", 32'(force_oct_off_o), 32'(exp_oct));
			oct_cycles++;
		end
		// Bit 0 becomes the value the next rising edge samples
		req_hist   = {req_hist[30:0], afi_rdata_en_i};
		full_hist  = {full_hist[30:0], afi_rdata_en_full_i};
	end

	// ********************
	// Stimulus
	// ********************
	initial
	begin
		int r;
		int first;
		int last;
		void'($urandom(32'h411f));
		pll_afi_clk = 1'b0;
		reset_n_afi_clk            <= 1'b0;
		afi_rdata_en_i             <= 1'b0;
		afi_rdata_en_full_i        <= 1'b0;
		seq_read_latency_counter_i <= LAT_CNT_WIDTH'(1);
		seq_read_fifo_reset_i      <= '0;
		ddio_wr_en_i               <= 1'b0;
		ddio_phy_dq_i              <= '0;
		$readmemh("read_datapath_testdata.txt", tdata);
		repeat (10) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		repeat (2) @(posedge pll_afi_clk);

		// A burst runs from its first record to the one flagged last
		r = 0;
		while (r < NUM_REC)
		begin
			first = r;
			last  = r;
			while ((last < NUM_REC - 1) && ((rec_field(last, 0) & FLAG_LAST) == '0))
				last++;
			if ((rec_field(first, 0) & FLAG_CLEAR) != '0)
				clear_fifos();
			@(posedge pll_afi_clk);
			seq_read_latency_counter_i <= LAT_CNT_WIDTH'(rec_field(first, 1));
			write_burst(first, last);
			// Write-only bursts leave stale words for the clear to discard
			if ((rec_field(first, 0) & FLAG_WRONLY) == '0)
			begin
				read_burst(first, last);
				wait_drain();
			end
			r = last + 1;
		end

		// Isolated and then consecutive full enables with no reads
		pulse_full_enable(1);
		pulse_full_enable(3);

		$display("NO ERRORS");
		$finish;
	end

endmodule
